//--- files.f
rtl/cpu_pkg.sv
rtl/pipe_if.sv
rtl/instr_decode.sv
rtl/reg_heap.sv
rtl/hazard_unit.sv
rtl/exec_stage.sv
rtl/mem_wb_stage.sv
rtl/zzcpu.sv
tests/tb_zzcpu.sv

//--- rtl/cpu_pkg.sv
package cpu_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	// machine word
	localparam int DATA_W = 16;
	// register index, eight registers
	localparam int REG_AW = 3;
	localparam int NUM_REGS = 8;
	// data ram address, low bits of the alu sum
	localparam int MEM_AW = 8;
	localparam int MEM_WORDS = 1 << MEM_AW;
	// opcode field in bits 15..11
	localparam int OP_W = 5;
	localparam int ALU_W = 3;

	//////////////////////////////
	// opcodes
	//////////////////////////////

	// rx = [10:8], ry = [7:5], rz = [4:2]
	// imm8 = [7:0], imm5 = [4:0] sign extended
	// unlisted codes decode as nop
	typedef enum logic [OP_W-1:0] {
		// no operation
		OP_NOP   = 5'd0,
		// rz = rx + ry
		OP_ADDU  = 5'd1,
		// rz = rx - ry
		OP_SUBU  = 5'd2,
		// rz = rx & ry
		OP_AND   = 5'd3,
		// rz = rx | ry
		OP_OR    = 5'd4,
		// rz = rx << ry[3:0]
		OP_SLL   = 5'd5,
		// rx = rx + sext(imm8)
		OP_ADDIU = 5'd6,
		// rx = zext(imm8)
		OP_LI    = 5'd7,
		// ry = mem[rx + sext(imm5)]
		OP_LW    = 5'd8,
		// mem[rx + sext(imm5)] = ry
		OP_SW    = 5'd9
	} op_e;

	//////////////////////////////
	// alu operations
	//////////////////////////////

	// passb just forwards operand b (li)
	typedef enum logic [ALU_W-1:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_SLL   = 3'd4,
		ALU_PASSB = 3'd5
	} alu_op_e;

endpackage

//--- rtl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
	input  logic                       clk,
	input  logic                       reset_i,
	dec_if.ex                          dec,
	input  logic                       stall_i,
	exmem_if.master                    exmem,
	input  logic                       wb_we_i,
	input  logic [cpu_pkg::REG_AW-1:0] wb_reg_i,
	input  logic [cpu_pkg::DATA_W-1:0] wb_data_i,
	output logic                       idex_memread_o,
	output logic [cpu_pkg::REG_AW-1:0] idex_regdst_o
);
	import cpu_pkg::*;

	// id/ex payload
	alu_op_e idex_alu_op;
	logic [DATA_W-1:0] idex_opa;
	logic [DATA_W-1:0] idex_opb;
	logic [DATA_W-1:0] idex_st_data;
	logic [REG_AW-1:0] idex_src_a;
	logic [REG_AW-1:0] idex_src_b;
	logic [REG_AW-1:0] idex_st_src;
	logic [REG_AW-1:0] idex_dst;
	logic idex_use_a;
	logic idex_use_b;
	// id/ex control
	logic idex_regwrite;
	logic idex_memread;
	logic idex_memwrite;
	// forwarded operands and alu out
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] st_val;
	logic [DATA_W-1:0] alu_res;

	//////////////////////////////
	// id/ex register
	//////////////////////////////

	// controls cleared on reset or stall, gives the bubble
	always_ff @(posedge clk) begin
		if (reset_i || stall_i) begin
			idex_regwrite <= 1'b0;
			idex_memread  <= 1'b0;
			idex_memwrite <= 1'b0;
		end else begin
			idex_regwrite <= dec.regwrite;
			idex_memread  <= dec.memread;
			idex_memwrite <= dec.memwrite;
		end
	end

	always_ff @(posedge clk) begin
		idex_alu_op  <= dec.alu_op;
		idex_opa     <= dec.opa;
		idex_opb     <= dec.opb;
		idex_st_data <= dec.st_data;
		idex_src_a   <= dec.src_a;
		idex_src_b   <= dec.src_b;
		idex_st_src  <= dec.st_src;
		idex_dst     <= dec.dst;
		idex_use_a   <= dec.use_a;
		idex_use_b   <= dec.use_b;
	end

	assign idex_memread_o = idex_memread;
	assign idex_regdst_o  = idex_dst;

	//////////////////////////////
	// forwarding
	//////////////////////////////

	// ex/mem first (not for loads), then mem/wb, else the register value
	function automatic logic [DATA_W-1:0] fwd(input logic en, input logic [REG_AW-1:0] src,
		input logic [DATA_W-1:0] val);
		logic [DATA_W-1:0] res;
		res = val;
		if (en && exmem.regwrite && !exmem.memread && exmem.dst == src)
			res = exmem.alu_res;
		else if (en && wb_we_i && wb_reg_i == src)
			res = wb_data_i;
		return res;
	endfunction

	always_comb begin
		// b holds an immediate when use_b is low
		op_a   = fwd(idex_use_a, idex_src_a, idex_opa);
		op_b   = fwd(idex_use_b, idex_src_b, idex_opb);
		st_val = fwd(idex_memwrite, idex_st_src, idex_st_data);
	end

	// alu
	always_comb begin
		case (idex_alu_op)
			ALU_ADD:   alu_res = op_a + op_b;
			ALU_SUB:   alu_res = op_a - op_b;
			ALU_AND:   alu_res = op_a & op_b;
			ALU_OR:    alu_res = op_a | op_b;
			// shift amount is the low four bits
			ALU_SLL:   alu_res = op_a << op_b[3:0];
			default:   alu_res = op_b;
		endcase
	end

	//////////////////////////////
	// ex/mem register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i) begin
			exmem.regwrite <= 1'b0;
			exmem.memread  <= 1'b0;
			exmem.memwrite <= 1'b0;
		end else begin
			exmem.regwrite <= idex_regwrite;
			exmem.memread  <= idex_memread;
			exmem.memwrite <= idex_memwrite;
		end
	end

	always_ff @(posedge clk) begin
		exmem.alu_res <= alu_res;
		exmem.st_data <= st_val;
		exmem.dst     <= idex_dst;
	end

	// decode never builds a load that also stores
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset_i)
		!(idex_memread && idex_memwrite));

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input  logic                       clk,
	input  logic                       reset_i,
	dec_if.haz                         dec,
	input  logic                       idex_memread_i,
	input  logic [cpu_pkg::REG_AW-1:0] idex_regdst_i,
	output logic                       stall_o
);
	import cpu_pkg::*;

	logic hit_a;
	logic hit_b;
	logic hit_st;

	//////////////////////////////
	// load-use compare
	//////////////////////////////

	// only sources the incoming instruction really reads
	assign hit_a  = dec.use_a && (dec.src_a == idex_regdst_i);
	assign hit_b  = dec.use_b && (dec.src_b == idex_regdst_i);
	// sw data comes from ry
	assign hit_st = dec.memwrite && (dec.st_src == idex_regdst_i);

	// load in id/ex can't forward from ex/mem yet, insert one bubble
	assign stall_o = idex_memread_i && (hit_a || hit_b || hit_st);

	// bubble pushes the load on to ex/mem, so a second stall is impossible
	a_one_cycle_stall: assert property (@(posedge clk) disable iff (reset_i)
		stall_o |=> !stall_o);

	// a load in id/ex always names a register of width REG_AW
	a_regdst_known: assert property (@(posedge clk) disable iff (reset_i)
		idex_memread_i |-> !$isunknown(idex_regdst_i));

endmodule

//--- rtl/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic [cpu_pkg::DATA_W-1:0] instr_i,
	output logic [cpu_pkg::REG_AW-1:0] rd_addr_a_o,
	output logic [cpu_pkg::REG_AW-1:0] rd_addr_b_o,
	input  logic [cpu_pkg::DATA_W-1:0] rd_data_a_i,
	input  logic [cpu_pkg::DATA_W-1:0] rd_data_b_i,
	dec_if.dec                         dec
);
	import cpu_pkg::*;

	op_e op;
	logic [REG_AW-1:0] rx;
	logic [REG_AW-1:0] ry;
	logic [REG_AW-1:0] rz;
	logic [DATA_W-1:0] imm8_s;
	logic [DATA_W-1:0] imm8_z;
	logic [DATA_W-1:0] imm5_s;

	// field split
	assign op = op_e'(instr_i[DATA_W-1 -: OP_W]);
	assign rx = instr_i[10:8];
	assign ry = instr_i[7:5];
	assign rz = instr_i[4:2];
	assign imm8_s = {{(DATA_W-8){instr_i[7]}}, instr_i[7:0]};
	assign imm8_z = {{(DATA_W-8){1'b0}}, instr_i[7:0]};
	assign imm5_s = {{(DATA_W-5){instr_i[4]}}, instr_i[4:0]};

	// port a always rx, port b always ry
	assign rd_addr_a_o = rx;
	assign rd_addr_b_o = ry;

	always_comb begin
		// defaults look like a nop
		dec.alu_op   = ALU_ADD;
		dec.opa      = rd_data_a_i;
		dec.opb      = rd_data_b_i;
		dec.src_a    = rx;
		dec.src_b    = ry;
		dec.use_a    = 1'b0;
		dec.use_b    = 1'b0;
		dec.st_data  = rd_data_b_i;
		dec.st_src   = ry;
		dec.dst      = rz;
		dec.regwrite = 1'b0;
		dec.memread  = 1'b0;
		dec.memwrite = 1'b0;
		case (op)
			OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLL: begin
				// three register form, rz destination
				dec.use_a    = 1'b1;
				dec.use_b    = 1'b1;
				dec.regwrite = 1'b1;
				case (op)
					OP_SUBU: dec.alu_op = ALU_SUB;
					OP_AND:  dec.alu_op = ALU_AND;
					OP_OR:   dec.alu_op = ALU_OR;
					OP_SLL:  dec.alu_op = ALU_SLL;
					default: dec.alu_op = ALU_ADD;
				endcase
			end
			OP_ADDIU: begin
				dec.use_a    = 1'b1;
				dec.opb      = imm8_s;
				dec.dst      = rx;
				dec.regwrite = 1'b1;
			end
			OP_LI: begin
				// no register source, never stalls
				dec.alu_op   = ALU_PASSB;
				dec.opb      = imm8_z;
				dec.dst      = rx;
				dec.regwrite = 1'b1;
			end
			OP_LW: begin
				dec.use_a    = 1'b1;
				dec.opb      = imm5_s;
				dec.dst      = ry;
				dec.regwrite = 1'b1;
				dec.memread  = 1'b1;
			end
			OP_SW: begin
				// address from rx, data from ry via st_data
				dec.use_a    = 1'b1;
				dec.opb      = imm5_s;
				dec.memwrite = 1'b1;
			end
			default: ;
		endcase
	end

	// opcode must be driven once out of reset
	a_op_known: assert property (@(posedge clk) disable iff (reset_i)
		!$isunknown(instr_i[DATA_W-1 -: OP_W]));

endmodule

//--- rtl/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
	input  logic                       clk,
	input  logic                       reset_i,
	exmem_if.slave                     exmem,
	output logic                       wb_we_o,
	output logic [cpu_pkg::REG_AW-1:0] wb_reg_o,
	output logic [cpu_pkg::DATA_W-1:0] wb_data_o
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] ram [MEM_WORDS];
	logic [MEM_AW-1:0] addr;
	logic [DATA_W-1:0] rd_word;
	// mem/wb register
	logic [DATA_W-1:0] memwb_alu;
	logic [DATA_W-1:0] memwb_ld_data;
	logic [REG_AW-1:0] memwb_dst;
	logic memwb_regwrite;
	logic memwb_load;

	//////////////////////////////
	// data ram
	//////////////////////////////

	// low address bits of the alu sum
	assign addr = exmem.alu_res[MEM_AW-1:0];
	// async read
	assign rd_word = ram[addr];

	// store lands at the clock edge
	always_ff @(posedge clk) begin
		if (exmem.memwrite) begin
			ram[addr] <= exmem.st_data;
		end
	end

	//////////////////////////////
	// mem/wb and writeback
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i) begin
			memwb_regwrite <= 1'b0;
			memwb_load     <= 1'b0;
		end else begin
			memwb_regwrite <= exmem.regwrite;
			memwb_load     <= exmem.memread;
		end
	end

	always_ff @(posedge clk) begin
		memwb_alu     <= exmem.alu_res;
		memwb_ld_data <= rd_word;
		memwb_dst     <= exmem.dst;
	end

	// loaded word for lw, alu result otherwise
	assign wb_we_o   = memwb_regwrite;
	assign wb_reg_o  = memwb_dst;
	assign wb_data_o = memwb_load ? memwb_ld_data : memwb_alu;

	// a load always ends in a register write
	a_load_writes: assert property (@(posedge clk) disable iff (reset_i)
		memwb_load |-> memwb_regwrite);

endmodule

//--- rtl/pipe_if.sv
`timescale 1ns/1ps

// decoded bundle, decode -> execute, hazard unit listens
interface dec_if;
	import cpu_pkg::*;

	alu_op_e alu_op;
	// operand values, b may hold an immediate
	logic [DATA_W-1:0] opa;
	logic [DATA_W-1:0] opb;
	logic [REG_AW-1:0] src_a;
	logic [REG_AW-1:0] src_b;
	// operand really read from a register
	logic use_a;
	logic use_b;
	// sw data path
	logic [DATA_W-1:0] st_data;
	logic [REG_AW-1:0] st_src;
	logic [REG_AW-1:0] dst;
	logic regwrite;
	logic memread;
	logic memwrite;

	modport dec (output alu_op, opa, opb, src_a, src_b, use_a, use_b,
		st_data, st_src, dst, regwrite, memread, memwrite);
	modport ex (input alu_op, opa, opb, src_a, src_b, use_a, use_b,
		st_data, st_src, dst, regwrite, memread, memwrite);
	// memwrite marks st_src as a live source
	modport haz (input src_a, src_b, use_a, use_b, st_src, memwrite);
endinterface

// ex/mem bundle, execute -> memory
interface exmem_if;
	import cpu_pkg::*;

	logic [DATA_W-1:0] alu_res;
	logic [DATA_W-1:0] st_data;
	logic [REG_AW-1:0] dst;
	logic regwrite;
	logic memread;
	logic memwrite;

	modport master (output alu_res, st_data, dst, regwrite, memread, memwrite);
	modport slave (input alu_res, st_data, dst, regwrite, memread, memwrite);
endinterface

//--- rtl/reg_heap.sv
`timescale 1ns/1ps

module reg_heap (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic [cpu_pkg::REG_AW-1:0] rd_addr_a_i,
	input  logic [cpu_pkg::REG_AW-1:0] rd_addr_b_i,
	output logic [cpu_pkg::DATA_W-1:0] rd_data_a_o,
	output logic [cpu_pkg::DATA_W-1:0] rd_data_b_o,
	input  logic                       we_i,
	input  logic [cpu_pkg::REG_AW-1:0] wr_addr_i,
	input  logic [cpu_pkg::DATA_W-1:0] wr_data_i
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] regs [NUM_REGS];

	// all registers read 0 after reset
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// write-through, a same-cycle read sees the value being written
	assign rd_data_a_o = (we_i && wr_addr_i == rd_addr_a_i) ? wr_data_i : regs[rd_addr_a_i];
	assign rd_data_b_o = (we_i && wr_addr_i == rd_addr_b_i) ? wr_data_i : regs[rd_addr_b_i];

	// writeback index from mem/wb must be clean
	a_wr_addr_known: assert property (@(posedge clk) disable iff (reset_i)
		we_i |-> !$isunknown(wr_addr_i));

endmodule

//--- rtl/zzcpu.sv
`timescale 1ns/1ps

module zzcpu (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic [cpu_pkg::DATA_W-1:0] instr_i,
	output logic                       stall_o,
	output logic                       wb_we_o,
	output logic [cpu_pkg::REG_AW-1:0] wb_reg_o,
	output logic [cpu_pkg::DATA_W-1:0] wb_data_o
);
	import cpu_pkg::*;

	// register heap read side
	logic [REG_AW-1:0] rd_addr_a;
	logic [REG_AW-1:0] rd_addr_b;
	logic [DATA_W-1:0] rd_data_a;
	logic [DATA_W-1:0] rd_data_b;
	// pending load in id/ex, for the hazard check
	logic idex_memread;
	logic [REG_AW-1:0] idex_regdst;

	dec_if   dec_bus ();
	exmem_if exmem_bus ();

	//////////////////////////////
	// decode side
	//////////////////////////////

	// instruction comes straight from outside, no fetch
	instr_decode u_decode (
		.clk         (clk),
		.reset_i     (reset_i),
		.instr_i     (instr_i),
		.rd_addr_a_o (rd_addr_a),
		.rd_addr_b_o (rd_addr_b),
		.rd_data_a_i (rd_data_a),
		.rd_data_b_i (rd_data_b),
		.dec         (dec_bus.dec)
	);

	// written from the writeback outputs
	reg_heap u_regs (
		.clk         (clk),
		.reset_i     (reset_i),
		.rd_addr_a_i (rd_addr_a),
		.rd_addr_b_i (rd_addr_b),
		.rd_data_a_o (rd_data_a),
		.rd_data_b_o (rd_data_b),
		.we_i        (wb_we_o),
		.wr_addr_i   (wb_reg_o),
		.wr_data_i   (wb_data_o)
	);

	hazard_unit u_hazard (
		.clk            (clk),
		.reset_i        (reset_i),
		.dec            (dec_bus.haz),
		.idex_memread_i (idex_memread),
		.idex_regdst_i  (idex_regdst),
		.stall_o        (stall_o)
	);

	//////////////////////////////
	// back end
	//////////////////////////////

	exec_stage u_exec (
		.clk            (clk),
		.reset_i        (reset_i),
		.dec            (dec_bus.ex),
		.stall_i        (stall_o),
		.exmem          (exmem_bus.master),
		.wb_we_i        (wb_we_o),
		.wb_reg_i       (wb_reg_o),
		.wb_data_i      (wb_data_o),
		.idex_memread_o (idex_memread),
		.idex_regdst_o  (idex_regdst)
	);

	mem_wb_stage u_memwb (
		.clk       (clk),
		.reset_i   (reset_i),
		.exmem     (exmem_bus.slave),
		.wb_we_o   (wb_we_o),
		.wb_reg_o  (wb_reg_o),
		.wb_data_o (wb_data_o)
	);

endmodule

//--- tests/tb_zzcpu.sv
`timescale 1ns/1ps

module tb_zzcpu;
	import cpu_pkg::*;

	localparam int MAX_RECS = 64;
	localparam int N_RANDOM = 200;
	localparam int CLK_NS = 8;

	logic clk;
	logic reset_i;
	logic [DATA_W-1:0] instr_i;
	logic stall_o;
	logic wb_we_o;
	logic [REG_AW-1:0] wb_reg_o;
	logic [DATA_W-1:0] wb_data_o;

	// four words per record, instr / flag / reg / value
	logic [15:0] vec [0:4*MAX_RECS-1];
	int n_recs;
	// architectural model
	logic [DATA_W-1:0] m_regs [NUM_REGS];
	logic [DATA_W-1:0] m_mem [MEM_WORDS];
	logic m_written [MEM_WORDS];
	// pending writebacks, oldest first
	logic [REG_AW-1:0] q_reg [$];
	logic [DATA_W-1:0] q_val [$];
	time q_time [$];
	// last accepted word, drives the expected stall
	time last_acc;
	logic last_lw;
	logic [REG_AW-1:0] last_lw_dst;
	logic [31:0] rng;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;

	zzcpu UUT (
		.clk       (clk),
		.reset_i   (reset_i),
		.instr_i   (instr_i),
		.stall_o   (stall_o),
		.wb_we_o   (wb_we_o),
		.wb_reg_o  (wb_reg_o),
		.wb_data_o (wb_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// true when the word reads register r as a source
	function automatic logic uses_reg(input logic [15:0] w, input logic [REG_AW-1:0] r);
		case (op_e'(w[15:11]))
			OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLL, OP_SW: return w[10:8] == r || w[7:5] == r;
			OP_ADDIU, OP_LW: return w[10:8] == r;
			default: return 1'b0;
		endcase
	endfunction

	// one instruction in program order
	task automatic apply_instr(input logic [15:0] w, output logic has_wb,
		output logic [REG_AW-1:0] rd, output logic [DATA_W-1:0] val);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [MEM_AW-1:0] addr;
		a = m_regs[w[10:8]];
		b = m_regs[w[7:5]];
		// rx plus sign extended imm5, low bits only
		addr = MEM_AW'(a + {{(DATA_W-5){w[4]}}, w[4:0]});
		has_wb = 1'b1;
		rd = w[4:2];
		val = '0;
		case (op_e'(w[15:11]))
			OP_ADDU: val = a + b;
			OP_SUBU: val = a - b;
			OP_AND: val = a & b;
			OP_OR: val = a | b;
			OP_SLL: val = a << b[3:0];
			OP_ADDIU: begin
				rd = w[10:8];
				val = a + {{(DATA_W-8){w[7]}}, w[7:0]};
			end
			OP_LI: begin
				rd = w[10:8];
				val = {{(DATA_W-8){1'b0}}, w[7:0]};
			end
			OP_LW: begin
				rd = w[7:5];
				val = m_mem[addr];
			end
			OP_SW: begin
				has_wb = 1'b0;
				m_mem[addr] = b;
				m_written[addr] = 1'b1;
			end
			default: has_wb = 1'b0;
		endcase
		if (has_wb)
			m_regs[rd] = val;
	endtask

	//////////////////////////////
	// drive and check
	//////////////////////////////

	// hold the word through any stall, then log it as accepted
	task automatic issue(input logic [15:0] w, output logic has_wb,
		output logic [REG_AW-1:0] rd, output logic [DATA_W-1:0] val);
		logic exp_stall;
		int stalls;
		stalls = 0;
		instr_i <= w;
		@(posedge clk);
		// load still in id/ex and feeding this word
		exp_stall = last_lw && (last_acc == $time - CLK_NS) && uses_reg(w, last_lw_dst);
		while (stall_o === 1'b1) begin
			stalls++;
			@(posedge clk);
		end
		checks++;
		if (stalls != int'(exp_stall)) begin
			errors++;
			$display("Fail stall_o cycles exp %h got %h", int'(exp_stall), stalls);
		end
		if (stall_o !== 1'b0) begin
			errors++;
			$display("stall_o was unknown when word %h was accepted", w);
		end
		apply_instr(w, has_wb, rd, val);
		if (has_wb) begin
			q_reg.push_back(rd);
			q_val.push_back(val);
			q_time.push_back($time);
		end
		last_acc = $time;
		last_lw = (w[15:11] == OP_LW);
		last_lw_dst = w[7:5];
	endtask

	// nops drain the pipe, then every writeback must be in
	task automatic finish_test(input int err0, input int n_instr);
		logic has_wb;
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] val;
		repeat (4) issue(16'h0000, has_wb, rd, val);
		if (q_reg.size() != 0) begin
			errors++;
			$display("%0d writebacks never arrived in test %0d", q_reg.size(), tests_run + 1);
			q_reg.delete();
			q_val.delete();
			q_time.delete();
		end
		tests_run++;
		if (errors != err0)
			tests_failed++;
		$display("test %0d: %0d instructions, %s", tests_run, n_instr,
			(errors == err0) ? "ok" : "failed");
	endtask

	// file records up to the next marker
	task automatic run_directed(inout int idx);
		logic has_wb;
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] val;
		int err0;
		int n;
		err0 = errors;
		n = 0;
		while (idx < n_recs && vec[4*idx] !== 16'hffff) begin
			issue(vec[4*idx], has_wb, rd, val);
			checks++;
			// model against the file
			if (has_wb !== vec[4*idx+1][0]) begin
				errors++;
				$display("Fail wb_we_o exp %h got %h", vec[4*idx+1][0], has_wb);
			end else if (has_wb && rd !== vec[4*idx+2][REG_AW-1:0]) begin
				errors++;
				$display("Fail wb_reg_o exp %h got %h", vec[4*idx+2][REG_AW-1:0], rd);
			end else if (has_wb && val !== vec[4*idx+3]) begin
				errors++;
				$display("Fail wb_data_o exp %h got %h", vec[4*idx+3], val);
			end
			idx++;
			n++;
		end
		// skip the marker
		idx++;
		finish_test(err0, n);
	endtask

	task automatic run_random();
		logic has_wb;
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] val;
		logic [15:0] w;
		logic [4:0] op;
		logic [REG_AW-1:0] rx;
		logic [4:0] imm;
		logic [MEM_AW-1:0] addr;
		logic found;
		int err0;
		int r;
		int k;
		err0 = errors;
		for (int i = 0; i < N_RANDOM; i++) begin
			rng = xorshift(rng);
			// opcodes 1 to 9
			op = 5'((rng[20:16] % 9) + 1);
			w = {op, rng[10:0]};
			if (op == OP_LW) begin
				// hunt for rx and imm5 that reach a written word
				found = 1'b0;
				for (r = 0; r < NUM_REGS; r++) begin
					for (k = 0; k < 32; k++) begin
						rx = w[10:8] + 3'(r);
						imm = w[4:0] + 5'(k);
						addr = MEM_AW'(m_regs[rx] + {{(DATA_W-5){imm[4]}}, imm});
						if (!found && m_written[addr]) begin
							found = 1'b1;
							w[10:8] = rx;
							w[4:0] = imm;
						end
					end
				end
				if (!found)
					w[15:11] = OP_LI;
			end
			issue(w, has_wb, rd, val);
		end
		finish_test(err0, N_RANDOM);
	endtask

	// writeback monitor, three edges after acceptance
	always @(posedge clk) begin
		if (!reset_i) begin
			if (wb_we_o === 1'b1) begin
				if (q_reg.size() == 0) begin
					errors++;
					$display("extra writeback to r%0d with nothing pending", wb_reg_o);
				end else begin
					checks++;
					if ($time - q_time[0] != 3 * CLK_NS) begin
						errors++;
						$display("Fail wb_we_o latency exp %h got %h", 3,
							($time - q_time[0]) / CLK_NS);
					end
					if (wb_reg_o !== q_reg[0]) begin
						errors++;
						$display("Fail wb_reg_o exp %h got %h", q_reg[0], wb_reg_o);
					end
					if (wb_data_o !== q_val[0]) begin
						errors++;
						$display("Fail wb_data_o exp %h got %h", q_val[0], wb_data_o);
					end
					void'(q_reg.pop_front());
					void'(q_val.pop_front());
					void'(q_time.pop_front());
				end
			end else if (wb_we_o !== 1'b0) begin
				errors++;
				$display("wb_we_o is unknown");
			end else if (q_time.size() > 0 && q_time[0] + 3 * CLK_NS <= $time) begin
				errors++;
				$display("writeback for r%0d did not show up three edges after acceptance",
					q_reg[0]);
				void'(q_reg.pop_front());
				void'(q_val.pop_front());
				void'(q_time.pop_front());
			end
		end
	end

	// watchdog, 4 cycles per record plus 1 us
	initial begin
		@(negedge reset_i);
		#((n_recs + N_RANDOM) * 4 * CLK_NS + 1000);
		$display("run timed out before all tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int idx;
		instr_i = '0;
		reset_i = 1'b1;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		last_acc = 0;
		last_lw = 1'b0;
		last_lw_dst = '0;
		rng = 32'h1354_53ea;
		for (int i = 0; i < NUM_REGS; i++)
			m_regs[i] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			m_written[i] = 1'b0;
		$readmemh("tests/zzcpu_tests.txt", vec);
		n_recs = 0;
		while (n_recs < MAX_RECS && !$isunknown(vec[4*n_recs]))
			n_recs++;
		if (n_recs == 0) begin
			errors++;
			$display("no records were read from the data file");
		end
		repeat (8) @(posedge clk);
		reset_i <= 1'b0;
		idx = 0;
		while (idx < n_recs)
			run_directed(idx);
		run_random();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- tests/zzcpu_tests.txt
// each line holds instruction word, writeback flag, register and value
// a line starting with ffff ends a test
0000 0 0 0000
3905 1 1 0005
0808 1 2 0000
09ec 1 3 0005
ffff 0 0 0000
3935 1 1 0035
3a0f 1 2 000f
094c 1 3 0044
1150 1 4 0026
1954 1 5 0005
2158 1 6 003f
2a3c 1 7 01e0
31fd 1 1 0032
ffff 0 0 0000
3910 1 1 0010
0928 1 2 0020
0a2c 1 3 0030
134c 1 3 0010
ffff 0 0 0000
3920 1 1 0020
3aab 1 2 00ab
4940 0 0 0000
4160 1 3 00ab
0b50 1 4 0156
3e5a 1 6 005a
49df 0 0 0000
41ff 1 7 005a
49e2 0 0 0000
4182 1 4 005a
ffff 0 0 0000
